//--- design/pipe_defs.svh
// Sizes shared by every block of the pipeline slice
// FETCH_DEPTH and DMEM_DEPTH must be powers of two
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Register and data path width
`define DATA_W      32

// Register address width, 32 registers
`define REG_ADDR_W  5

// Fetch queue entries, also the credit count the source starts with
`define FETCH_DEPTH 4

// Retire slots granted to the core after reset
`define RET_CREDITS 2

// Data memory words
`define DMEM_DEPTH  16

// One bit per iteration in the multiply/divide unit
`define MD_CYCLES   32

`endif

//--- design/pipe_pkg.sv
// Types shared by the pipeline slice
// Immediates are 16 bits and always zero-extended in ID
`include "pipe_defs.svh"

package pipe_pkg;

  // Opcode set of the slice
  typedef enum logic [2:0] {
    OP_NOP   = 3'd0,
    OP_ADD   = 3'd1,
    OP_SUB   = 3'd2,
    OP_ADDI  = 3'd3,
    OP_LOAD  = 3'd4,
    OP_STORE = 3'd5,
    OP_MUL   = 3'd6,
    OP_DIVU  = 3'd7
  } opcode_e;

  // Instruction as delivered by the source
  typedef struct packed {
    opcode_e                op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [15:0]            imm;
  } instr_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic                   valid;
    opcode_e                op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    // Forwarded operand values
    logic [`DATA_W-1:0]     a;
    logic [`DATA_W-1:0]     b;
    // Immediate after zero extension
    logic [`DATA_W-1:0]     imm;
  } idex_t;

  // Retire record, also the MEM/WB payload
  typedef struct packed {
    opcode_e                op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`DATA_W-1:0]     value;
  } retire_t;

  // Multiply/divide sequencer
  typedef enum logic [1:0] {
    MD_IDLE,
    MD_RUN,
    MD_DONE
  } md_state_e;

endpackage

//--- design/fetch_queue.sv
// Instruction queue in front of ID with a credit-based input
// Source starts with FETCH_DEPTH credits and spends one per valid cycle
`timescale 1ns/1ps
`include "pipe_defs.svh"

module fetch_queue (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  input  pipe_pkg::instr_t in_instr,
  input  logic             pop,
  output logic             q_valid,
  output pipe_pkg::instr_t q_instr,
  output logic             in_credit
);

  localparam int PTR_W = $clog2(`FETCH_DEPTH);

  pipe_pkg::instr_t mem [`FETCH_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One bit wider than the pointers to tell full from empty
  logic [PTR_W:0]   count;

  assign q_valid = (count != '0);
  assign q_instr = mem[rd_ptr];

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count     <= count + {{PTR_W{1'b0}}, in_valid} - {{PTR_W{1'b0}}, pop};
      // Each freed entry goes back to the source one cycle later
      in_credit <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_instr;
    end
  end

  // Source credit accounting keeps pushes away from a full queue
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> (count < `FETCH_DEPTH));

  // ID only pops an entry that is present
  a_pop_valid: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> q_valid);

endmodule

//--- design/hazard_detection_unit.sv
// Stall and bubble control for IF/ID and ID/EX
// Combinational only; clk samples the assertions and nothing else
`timescale 1ns/1ps
`include "pipe_defs.svh"

module hazard_detection_unit (
  input  logic                   clk,
  input  logic [`REG_ADDR_W-1:0] ifid_rs1,
  input  logic [`REG_ADDR_W-1:0] ifid_rs2,
  input  logic                   idex_is_load,
  input  logic [`REG_ADDR_W-1:0] idex_rd,
  input  logic                   idex_is_mul_div,
  input  logic                   mul_div_busy,
  input  logic                   ex_hold,
  output logic                   stall_ifid,
  output logic                   bubble_idex
);

  logic rs1_hazard;
  logic rs2_hazard;
  logic load_use_hazard;
  logic mul_div_stall;

  // x0 never carries a dependency
  assign rs1_hazard = (idex_rd == ifid_rs1) && (idex_rd != '0);
  assign rs2_hazard = (idex_rd == ifid_rs2) && (idex_rd != '0);

  // Load result only reaches ID through WB one cycle later
  assign load_use_hazard = idex_is_load && (rs1_hazard || rs2_hazard);

  // Catch the M op on its first EX cycle before busy rises
  assign mul_div_stall = mul_div_busy || idex_is_mul_div;

  // Multi-cycle and back-pressure stalls keep ID/EX in place
  assign stall_ifid  = load_use_hazard || mul_div_stall || ex_hold;

  // A held EX keeps the load in ID/EX so no bubble is inserted
  assign bubble_idex = load_use_hazard && !ex_hold;

  // Bubble leaves ID/EX empty once the load has moved on
  a_bubble_stalls: assert property (@(posedge clk)
    bubble_idex |=> !idex_is_load);

  // Frozen EX stage cannot drop the load it is holding
  a_hold_no_bubble: assert property (@(posedge clk)
    (ex_hold && idex_is_load) |=> (idex_is_load && $stable(idex_rd)));

endmodule

//--- design/id_stage.sv
// Decode stage with IF/ID, register file and ID/EX registers
// x0 reads as zero; the file is written from MEM/WB while it holds a result
// Operand priority is EX result, then MEM/WB result, then the file
`timescale 1ns/1ps
`include "pipe_defs.svh"

module id_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   q_valid,
  input  pipe_pkg::instr_t       q_instr,
  output logic                   q_pop,
  input  logic                   stall_ifid,
  input  logic                   bubble_idex,
  input  logic                   ex_fwd_valid,
  input  logic [`REG_ADDR_W-1:0] ex_rd,
  input  logic [`DATA_W-1:0]     ex_value,
  input  logic                   wb_valid,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`DATA_W-1:0]     wb_value,
  output logic [`REG_ADDR_W-1:0] ifid_rs1,
  output logic [`REG_ADDR_W-1:0] ifid_rs2,
  output pipe_pkg::idex_t        idex
);

  logic               ifid_valid;
  pipe_pkg::instr_t   ifid;
  logic [`DATA_W-1:0] regs [1 << `REG_ADDR_W];
  logic [`DATA_W-1:0] rs1_val;
  logic [`DATA_W-1:0] rs2_val;

  // Operand lookup with bypass from the later stages
  function automatic logic [`DATA_W-1:0] read_operand(input logic [`REG_ADDR_W-1:0] rs);
    logic [`DATA_W-1:0] val;
    if (rs == '0) begin
      val = '0;
    end else if (ex_fwd_valid && (ex_rd == rs)) begin
      val = ex_value;
    end else if (wb_valid && (wb_rd == rs)) begin
      val = wb_value;
    end else begin
      val = regs[rs];
    end
    return val;
  endfunction

  // IF/ID fills when empty or when its instruction moves to ID/EX
  assign q_pop = q_valid && (!ifid_valid || !stall_ifid);

  // Empty IF/ID shows x0 so it can never match a load
  assign ifid_rs1 = ifid_valid ? ifid.rs1 : '0;
  assign ifid_rs2 = ifid_valid ? ifid.rs2 : '0;

  always_comb begin
    rs1_val = read_operand(ifid.rs1);
    rs2_val = read_operand(ifid.rs2);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ifid_valid <= 1'b0;
    end else if (q_pop) begin
      ifid_valid <= 1'b1;
    end else if (!stall_ifid) begin
      ifid_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      ifid <= q_instr;
    end
  end

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wb_valid && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_value;
    end
  end

  // Bubble empties ID/EX; a plain stall holds it for EX hold or the M unit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idex.valid <= 1'b0;
    end else if (bubble_idex) begin
      idex.valid <= 1'b0;
    end else if (!stall_ifid) begin
      idex.valid <= ifid_valid;
      idex.op    <= ifid.op;
      idex.rd    <= ifid.rd;
      idex.rs1   <= ifid.rs1;
      idex.rs2   <= ifid.rs2;
      idex.a     <= rs1_val;
      idex.b     <= rs2_val;
      idex.imm   <= {{(`DATA_W-16){1'b0}}, ifid.imm};
    end
  end

endmodule

//--- design/mul_div_unit.sv
// Iterative unsigned multiply and divide, one bit per cycle
// MUL keeps the low DATA_W bits; DIVU by zero gives all ones
// start is taken in MD_IDLE or MD_DONE and the result holds until the next start
`timescale 1ns/1ps
`include "pipe_defs.svh"

module mul_div_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  pipe_pkg::opcode_e  op,
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  output logic               busy,
  output logic               done,
  output logic [`DATA_W-1:0] result
);

  localparam int CNT_W = $clog2(`MD_CYCLES);

  pipe_pkg::md_state_e state;
  logic [CNT_W-1:0]    cnt;
  logic                is_div;
  // Product, or partial remainder when dividing
  logic [`DATA_W-1:0]  acc;
  // Multiplicand or divisor
  logic [`DATA_W-1:0]  opnd;
  // Multiplier, or dividend shifting out as quotient shifts in
  logic [`DATA_W-1:0]  shf;
  logic [`DATA_W:0]    rem_sh;
  logic [`DATA_W:0]    rem_sub;

  assign busy   = (state == pipe_pkg::MD_RUN);
  assign done   = (state == pipe_pkg::MD_DONE);
  assign result = is_div ? shf : acc;

  // Next dividend bit into the remainder, then trial subtract
  assign rem_sh  = {acc, shf[`DATA_W-1]};
  assign rem_sub = rem_sh - {1'b0, opnd};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= pipe_pkg::MD_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        pipe_pkg::MD_IDLE, pipe_pkg::MD_DONE: begin
          if (start) begin
            state <= pipe_pkg::MD_RUN;
            cnt   <= '0;
          end
        end
        pipe_pkg::MD_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(`MD_CYCLES - 1)) begin
            state <= pipe_pkg::MD_DONE;
          end
        end
        default: state <= pipe_pkg::MD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      is_div <= (op == pipe_pkg::OP_DIVU);
      acc    <= '0;
      opnd   <= (op == pipe_pkg::OP_DIVU) ? b : a;
      shf    <= (op == pipe_pkg::OP_DIVU) ? a : b;
    end else if (busy) begin
      if (is_div) begin
        // Borrow means restore; zero divisor never borrows
        shf <= {shf[`DATA_W-2:0], !rem_sub[`DATA_W]};
        acc <= rem_sub[`DATA_W] ? rem_sh[`DATA_W-1:0] : rem_sub[`DATA_W-1:0];
      end else begin
        if (shf[0]) begin
          acc <= acc + opnd;
        end
        opnd <= opnd << 1;
        shf  <= shf >> 1;
      end
    end
  end

  // EX issues each M op once and waits for done
  a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> !busy);

endmodule

//--- design/execute_stage.sv
// EX and MEM/WB stages with data memory and retire credit counter
// Memory addresses are word indices modulo DMEM_DEPTH
// Stores retire with rd 0 and the stored data as value
`timescale 1ns/1ps
`include "pipe_defs.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  pipe_pkg::idex_t        idex,
  output logic                   ex_fwd_valid,
  output logic [`REG_ADDR_W-1:0] ex_rd,
  output logic [`DATA_W-1:0]     ex_value,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`DATA_W-1:0]     wb_value,
  output logic                   idex_is_load,
  output logic                   idex_is_mul_div,
  output logic                   mul_div_busy,
  output logic                   ex_hold,
  input  logic                   ret_credit,
  output logic                   ret_valid,
  output pipe_pkg::retire_t      ret
);

  localparam int ADDR_W = $clog2(`DMEM_DEPTH);
  localparam int CRD_W  = $clog2(`RET_CREDITS + 1);

  logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
  logic               is_md;
  logic               md_start;
  logic               md_issued;
  logic               md_done;
  logic               md_ready;
  logic [`DATA_W-1:0] md_result;
  logic [`DATA_W-1:0] addr_sum;
  logic [ADDR_W-1:0]  addr;
  logic [`DATA_W-1:0] ex_result;
  logic               memwb_valid;
  pipe_pkg::retire_t  memwb;
  logic [CRD_W-1:0]   credits;

  // Everything except NOP and STORE updates rd
  function automatic logic writes_rd(input pipe_pkg::opcode_e op);
    return !(op inside {pipe_pkg::OP_NOP, pipe_pkg::OP_STORE});
  endfunction

  assign is_md        = idex.valid && (idex.op inside {pipe_pkg::OP_MUL, pipe_pkg::OP_DIVU});
  assign idex_is_load = idex.valid && (idex.op == pipe_pkg::OP_LOAD);

  // One start per M op, result counts only after its own start
  assign md_start        = is_md && !md_issued;
  assign md_ready        = md_issued && md_done;
  assign idex_is_mul_div = is_md && !md_ready;

  mul_div_unit u_mul_div (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (md_start),
    .op     (idex.op),
    .a      (idex.a),
    .b      (idex.b),
    .busy   (mul_div_busy),
    .done   (md_done),
    .result (md_result)
  );

  // Shared by ADDI and the memory address
  assign addr_sum = idex.a + idex.imm;
  assign addr     = addr_sum[ADDR_W-1:0];

  always_comb begin
    case (idex.op)
      pipe_pkg::OP_ADD:   ex_result = idex.a + idex.b;
      pipe_pkg::OP_SUB:   ex_result = idex.a - idex.b;
      pipe_pkg::OP_ADDI:  ex_result = addr_sum;
      pipe_pkg::OP_LOAD:  ex_result = dmem[addr];
      pipe_pkg::OP_STORE: ex_result = idex.b;
      pipe_pkg::OP_MUL,
      pipe_pkg::OP_DIVU:  ex_result = md_result;
      default:            ex_result = '0;
    endcase
  end

  // Loads forward from WB only; M ops once their result is in
  assign ex_fwd_valid = idex.valid && writes_rd(idex.op) && !idex_is_load && !idex_is_mul_div;
  assign ex_rd        = idex.rd;
  assign ex_value     = ex_result;

  // Full MEM/WB without a credit freezes EX
  assign ret_valid = memwb_valid && (credits != '0);
  assign ex_hold   = memwb_valid && (credits == '0);
  assign ret       = memwb;

  assign wb_valid = memwb_valid && writes_rd(memwb.op);
  assign wb_rd    = memwb.rd;
  assign wb_value = memwb.value;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      md_issued <= 1'b0;
    end else if (md_start) begin
      md_issued <= 1'b1;
    end else if (md_ready && !ex_hold) begin
      md_issued <= 1'b0;
    end
  end

  // Pending M op leaves a gap in MEM/WB
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      memwb_valid <= 1'b0;
    end else if (!ex_hold) begin
      memwb_valid <= idex.valid && !idex_is_mul_div;
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_hold) begin
      memwb.op    <= idex.op;
      memwb.rd    <= (idex.op == pipe_pkg::OP_STORE) ? '0 : idex.rd;
      memwb.value <= ex_result;
      if (idex.valid && (idex.op == pipe_pkg::OP_STORE)) begin
        dmem[addr] <= idex.b;
      end
    end
  end

  // Consumer grants add up, each retire spends one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= CRD_W'(`RET_CREDITS);
    end else begin
      credits <= credits + CRD_W'(ret_credit) - CRD_W'(ret_valid);
    end
  end

  // Consumer never returns more slots than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
    (ret_credit && !ret_valid) |-> (credits < CRD_W'(`RET_CREDITS)));

  // Held EX sees the same ID/EX contents on the next cycle
  a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
    ex_hold |=> $stable(idex));

endmodule

//--- design/core_top.sv
// Pipeline slice with credit-based instruction input and retire output
// Source starts with FETCH_DEPTH credits and the core with RET_CREDITS
`timescale 1ns/1ps
`include "pipe_defs.svh"

module core_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  pipe_pkg::instr_t  in_instr,
  output logic              in_credit,
  output logic              ret_valid,
  output pipe_pkg::retire_t ret,
  input  logic              ret_credit
);

  logic                   q_valid;
  pipe_pkg::instr_t       q_instr;
  logic                   q_pop;
  pipe_pkg::idex_t        idex;
  logic [`REG_ADDR_W-1:0] ifid_rs1;
  logic [`REG_ADDR_W-1:0] ifid_rs2;
  logic                   stall_ifid;
  logic                   bubble_idex;
  // Bypass paths back into ID
  logic                   ex_fwd_valid;
  logic [`REG_ADDR_W-1:0] ex_rd;
  logic [`DATA_W-1:0]     ex_value;
  logic                   wb_valid;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`DATA_W-1:0]     wb_value;
  // EX status for the hazard unit
  logic                   idex_is_load;
  logic                   idex_is_mul_div;
  logic                   mul_div_busy;
  logic                   ex_hold;

  fetch_queue u_fetch_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .pop       (q_pop),
    .q_valid   (q_valid),
    .q_instr   (q_instr),
    .in_credit (in_credit)
  );

  id_stage u_id_stage (
    .clk          (clk),
    .arst_n       (arst_n),
    .q_valid      (q_valid),
    .q_instr      (q_instr),
    .q_pop        (q_pop),
    .stall_ifid   (stall_ifid),
    .bubble_idex  (bubble_idex),
    .ex_fwd_valid (ex_fwd_valid),
    .ex_rd        (ex_rd),
    .ex_value     (ex_value),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .wb_value     (wb_value),
    .ifid_rs1     (ifid_rs1),
    .ifid_rs2     (ifid_rs2),
    .idex         (idex)
  );

  hazard_detection_unit u_hazard (
    .clk             (clk),
    .ifid_rs1        (ifid_rs1),
    .ifid_rs2        (ifid_rs2),
    .idex_is_load    (idex_is_load),
    .idex_rd         (idex.rd),
    .idex_is_mul_div (idex_is_mul_div),
    .mul_div_busy    (mul_div_busy),
    .ex_hold         (ex_hold),
    .stall_ifid      (stall_ifid),
    .bubble_idex     (bubble_idex)
  );

  execute_stage u_execute (
    .clk             (clk),
    .arst_n          (arst_n),
    .idex            (idex),
    .ex_fwd_valid    (ex_fwd_valid),
    .ex_rd           (ex_rd),
    .ex_value        (ex_value),
    .wb_valid        (wb_valid),
    .wb_rd           (wb_rd),
    .wb_value        (wb_value),
    .idex_is_load    (idex_is_load),
    .idex_is_mul_div (idex_is_mul_div),
    .mul_div_busy    (mul_div_busy),
    .ex_hold         (ex_hold),
    .ret_credit      (ret_credit),
    .ret_valid       (ret_valid),
    .ret             (ret)
  );

endmodule

//--- tb/tb_core.sv
// Directed testbench for core_top with credit-based input and retire sides
// Registers and data memory are not reset, so every test reads only locations written earlier
// Checks cover retire order and values only, never exact latency
`timescale 1ns/1ps
`include "pipe_defs.svh"

module tb_core;

  localparam int RW        = `REG_ADDR_W;
  localparam int MEM_AW    = $clog2(`DMEM_DEPTH);
  // Consumer policies for retire credits
  localparam int CONS_NOW  = 0;
  localparam int CONS_HOLD = 1;
  localparam int CONS_RAND = 2;

  logic              clk = 1'b0;
  logic              arst_n = 1'b0;
  logic              in_valid;
  pipe_pkg::instr_t  in_instr;
  logic              in_credit;
  logic              ret_valid;
  pipe_pkg::retire_t ret;
  logic              ret_credit;

  // Reference model state
  logic [`DATA_W-1:0] ref_regs [1 << `REG_ADDR_W];
  logic [`DATA_W-1:0] ref_mem [`DMEM_DEPTH];

  pipe_pkg::instr_t  send_q [$];
  pipe_pkg::retire_t exp_q [$];
  logic [31:0]       lcg_state = 32'h1bd4d80d;
  string             cur_test = "reset";
  int                cons_mode = CONS_NOW;
  int                send_credits = `FETCH_DEPTH;
  int                credits_back = 0;
  int                issued = 0;
  int                retired = 0;
  int                granted = 0;
  int                owed = 0;
  int                value_errors = 0;
  int                other_errors = 0;

  core_top u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .in_credit  (in_credit),
    .ret_valid  (ret_valid),
    .ret        (ret),
    .ret_credit (ret_credit)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pipe_pkg::instr_t make_instr(input pipe_pkg::opcode_e op, input int rd,
                                                  input int rs1, input int rs2, input int imm);
    pipe_pkg::instr_t ins;
    ins.op  = op;
    ins.rd  = RW'(rd);
    ins.rs1 = RW'(rs1);
    ins.rs2 = RW'(rs2);
    ins.imm = 16'(imm);
    return ins;
  endfunction

  // Any opcode but NOP, registers x0..x7 only
  function automatic pipe_pkg::instr_t random_instr();
    logic [31:0]      r;
    pipe_pkg::instr_t ins;
    r       = next_rand();
    ins.op  = pipe_pkg::opcode_e'(3'(1 + (r[31:24] % 7)));
    ins.rd  = RW'(r[2:0]);
    ins.rs1 = RW'(r[5:3]);
    ins.rs2 = RW'(r[8:6]);
    ins.imm = r[23:8];
    return ins;
  endfunction

  // Architectural effect of one instruction in program order
  function automatic pipe_pkg::retire_t model_step(input pipe_pkg::instr_t ins);
    pipe_pkg::retire_t  r;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] sum;
    logic [MEM_AW-1:0]  addr;
    a       = (ins.rs1 == '0) ? '0 : ref_regs[ins.rs1];
    b       = (ins.rs2 == '0) ? '0 : ref_regs[ins.rs2];
    sum     = a + {{(`DATA_W-16){1'b0}}, ins.imm};
    // Word index modulo the memory depth
    addr    = sum[MEM_AW-1:0];
    r.op    = ins.op;
    r.rd    = ins.rd;
    r.value = '0;
    case (ins.op)
      pipe_pkg::OP_ADD:  r.value = a + b;
      pipe_pkg::OP_SUB:  r.value = a - b;
      pipe_pkg::OP_ADDI: r.value = sum;
      pipe_pkg::OP_LOAD: r.value = ref_mem[addr];
      pipe_pkg::OP_STORE: begin
        ref_mem[addr] = b;
        r.rd          = '0;
        r.value       = b;
      end
      // Low half of the product
      pipe_pkg::OP_MUL:  r.value = a * b;
      pipe_pkg::OP_DIVU: r.value = (b == '0) ? '1 : a / b;
      default:           r.value = '0;
    endcase
    if ((ins.op != pipe_pkg::OP_STORE) && (ins.op != pipe_pkg::OP_NOP) && (ins.rd != '0)) begin
      ref_regs[ins.rd] = r.value;
    end
    return r;
  endfunction

  task automatic issue(input pipe_pkg::instr_t ins);
    exp_q.push_back(model_step(ins));
    send_q.push_back(ins);
    issued++;
  endtask

  task automatic check_retire(input string what, input pipe_pkg::retire_t exp,
                              input pipe_pkg::retire_t act);
    if (exp !== act) begin
      $display("ERR %s %s: expected op %0d rd %0d value %08h, actual op %0d rd %0d value %08h",
               cur_test, what, exp.op, exp.rd, exp.value, act.op, act.rd, act.value);
      value_errors++;
    end
  endtask

  task automatic check_credit_count(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      value_errors++;
    end
  endtask

  // One input cycle, spending only credits the queue gave back
  task automatic send_step();
    if (!arst_n) begin
      send_credits = `FETCH_DEPTH;
      in_valid    <= 1'b0;
    end else begin
      if (in_credit) begin
        send_credits++;
        credits_back++;
      end
      if ((send_credits > 0) && (send_q.size() > 0)) begin
        in_instr <= send_q.pop_front();
        in_valid <= 1'b1;
        send_credits--;
      end else begin
        in_valid <= 1'b0;
      end
    end
  endtask

  // Retire side: compare each record, then decide on a credit for next cycle
  task automatic consume_step();
    logic [31:0] r;
    logic        give;
    if (!arst_n) begin
      ret_credit <= 1'b0;
    end else begin
      if (ret_valid) begin
        retired++;
        if (retired > `RET_CREDITS + granted) begin
          $display("%s: retire record %0d arrived without a credit", cur_test, retired);
          other_errors++;
        end
        if (exp_q.size() == 0) begin
          $display("%s: retire record arrived with nothing outstanding", cur_test);
          other_errors++;
        end else begin
          check_retire($sformatf("retire %0d", retired), exp_q.pop_front(), ret);
        end
        owed++;
      end
      give = 1'b0;
      if (cons_mode == CONS_NOW) begin
        give = (owed > 0);
      end else if (cons_mode == CONS_RAND) begin
        r    = next_rand();
        give = (owed > 0) && r[17];
      end
      ret_credit <= give;
      if (give) begin
        owed--;
        granted++;
      end
    end
  endtask

  initial begin
    in_valid = 1'b0;
    in_instr = '0;
    forever begin
      @(posedge clk);
      send_step();
    end
  end

  initial begin
    ret_credit = 1'b0;
    forever begin
      @(posedge clk);
      consume_step();
    end
  end

  task automatic wait_retired(input int target, input int limit);
    int cycles = 0;
    while ((retired < target) && (cycles < limit)) begin
      @(negedge clk);
      cycles++;
    end
    if (retired < target) begin
      $display("%s: timed out after %0d cycles with %0d of %0d records retired",
               cur_test, limit, retired, target);
      other_errors++;
    end
  endtask

  task automatic test_reset_idle();
    int ret_pulses = 0;
    int credit_pulses = 0;
    int flag_cycles = 0;
    cur_test = "reset_idle";
    repeat (10) begin
      @(negedge clk);
      if (ret_valid !== 1'b0) ret_pulses++;
      if (in_credit !== 1'b0) credit_pulses++;
      if ((u_dut.stall_ifid !== 1'b0) || (u_dut.bubble_idex !== 1'b0) ||
          (u_dut.mul_div_busy !== 1'b0)) begin
        flag_cycles++;
      end
    end
    check_credit_count("ret_valid cycles", 0, ret_pulses);
    check_credit_count("in_credit cycles", 0, credit_pulses);
    check_credit_count("hazard flag cycles", 0, flag_cycles);
  endtask

  task automatic test_alu();
    @(negedge clk);
    cur_test = "alu";
    for (int r = 1; r <= 8; r++) begin
      issue(make_instr(pipe_pkg::OP_ADDI, r, 0, 0, r * 'h111 + 7));
    end
    // Back-to-back dependencies use the EX and WB bypasses
    issue(make_instr(pipe_pkg::OP_ADD, 9, 1, 2, 0));
    issue(make_instr(pipe_pkg::OP_SUB, 10, 1, 3, 0));
    issue(make_instr(pipe_pkg::OP_ADD, 10, 10, 9, 0));
    issue(make_instr(pipe_pkg::OP_ADDI, 11, 10, 0, 'hffff));
    // Writes to x0 retire but leave it zero
    issue(make_instr(pipe_pkg::OP_ADD, 0, 4, 5, 0));
    issue(make_instr(pipe_pkg::OP_ADD, 12, 0, 6, 0));
    issue(make_instr(pipe_pkg::OP_ADDI, 0, 0, 0, 1234));
    issue(make_instr(pipe_pkg::OP_SUB, 13, 7, 0, 0));
    wait_retired(issued, 200);
  endtask

  task automatic test_load_use();
    @(negedge clk);
    cur_test = "load_use";
    // Fill every word with a value tied to its address
    for (int i = 0; i < `DMEM_DEPTH; i++) begin
      issue(make_instr(pipe_pkg::OP_ADDI, 14, 0, 0, 'h0a51 + i * 'h0123));
      issue(make_instr(pipe_pkg::OP_STORE, 0, 0, 14, i));
    end
    issue(make_instr(pipe_pkg::OP_STORE, 0, 1, 5, 3));
    issue(make_instr(pipe_pkg::OP_LOAD, 15, 1, 0, 3));
    // Dependent right after the load, on rs1 and then rs2
    issue(make_instr(pipe_pkg::OP_ADD, 16, 15, 2, 0));
    issue(make_instr(pipe_pkg::OP_SUB, 17, 3, 15, 0));
    issue(make_instr(pipe_pkg::OP_LOAD, 18, 0, 0, 7));
    issue(make_instr(pipe_pkg::OP_ADD, 18, 18, 18, 0));
    // Load into x0 carries no dependency
    issue(make_instr(pipe_pkg::OP_LOAD, 0, 0, 0, 2));
    issue(make_instr(pipe_pkg::OP_ADD, 19, 0, 4, 0));
    wait_retired(issued, 400);
  endtask

  task automatic test_mul_div();
    @(negedge clk);
    cur_test = "mul_div";
    issue(make_instr(pipe_pkg::OP_MUL, 20, 1, 2, 0));
    issue(make_instr(pipe_pkg::OP_ADD, 21, 20, 1, 0));
    issue(make_instr(pipe_pkg::OP_DIVU, 22, 20, 3, 0));
    // Divide by zero
    issue(make_instr(pipe_pkg::OP_DIVU, 23, 4, 0, 0));
    issue(make_instr(pipe_pkg::OP_SUB, 24, 23, 1, 0));
    issue(make_instr(pipe_pkg::OP_ADDI, 25, 0, 0, 'hffff));
    issue(make_instr(pipe_pkg::OP_MUL, 26, 25, 25, 0));
    issue(make_instr(pipe_pkg::OP_DIVU, 27, 26, 25, 0));
    issue(make_instr(pipe_pkg::OP_ADD, 28, 27, 26, 0));
    wait_retired(issued, 1000);
  endtask

  task automatic test_backpressure();
    int base;
    @(negedge clk);
    cur_test = "backpressure";
    cons_mode = CONS_HOLD;
    base = retired;
    // Ten dependent ops, more than the core and queue can hold
    for (int i = 1; i <= 10; i++) begin
      issue(make_instr(pipe_pkg::OP_ADDI, 8 + i, 7 + i, 0, i));
    end
    wait_retired(base + `RET_CREDITS, 100);
    // Observation window with no credits going back
    repeat (30) @(negedge clk);
    check_credit_count("records retired while held", `RET_CREDITS, retired - base);
    check_credit_count("sender credits while held", 0, send_credits);
    cons_mode = CONS_NOW;
    wait_retired(issued, 300);
  endtask

  task automatic test_stream();
    int credit_base;
    @(negedge clk);
    cur_test = "stream";
    cons_mode = CONS_RAND;
    credit_base = credits_back;
    for (int i = 0; i < 20; i++) begin
      issue(random_instr());
    end
    wait_retired(issued, 3000);
    check_credit_count("in_credit pulses", 20, credits_back - credit_base);
    check_credit_count("sender credits at end", `FETCH_DEPTH, send_credits);
  endtask

  initial begin
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    test_reset_idle();
    test_alu();
    test_load_use();
    test_mul_div();
    test_backpressure();
    test_stream();
    if (exp_q.size() != 0) begin
      $display("%0d expected retire records never arrived", exp_q.size());
      other_errors++;
    end
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+design
design/pipe_pkg.sv
design/fetch_queue.sv
design/hazard_detection_unit.sv
design/id_stage.sv
design/mul_div_unit.sv
design/execute_stage.sv
design/core_top.sv
tb/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_core -o sim_core \
  && ./obj_dir/sim_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
